/* sim.f */
source/hazard_pkg.sv
source/ex_stage_if.sv
source/load_use_detector.sv
source/access_latency_stall.sv
source/stall_flush_control.sv
source/stage_valid_tracker.sv
source/hazard_unit_top.sv
dv/hazard_unit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the hazard unit testbench with Verilator and runs it once.
# The result comes from the pass line in the simulation output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module hazard_unit_tb -f sim.f \
  -Mdir obj_dir -o hazard_unit_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_output="$(./obj_dir/hazard_unit_sim)"
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -Fxq "test passed"; then
  exit 0
fi
exit 1

/* dv/hazard_unit_tb.sv */
/*
  Table-driven testbench for the hazard unit, one table row per clock cycle.
  Checks the fill strobes first, then load-use, CSR/MMIO, flush and WFI/trap rows.
*/
`default_nettype none

module hazard_unit_tb;
  import hazard_pkg::*;

  localparam int FILL_TIMEOUT = 20;
  // IF, PD and ID must each take an instruction before the PC is valid
  localparam int PC_VLD_CYCLE = 3;

  // One cycle of stimulus and the outputs expected in that cycle
  typedef struct {
    int              test;
    logic [3:0]      ex_cls;   // load, multiply, divide, csr
    reg_addr_t       dest;
    reg_addr_t       src1;
    reg_addr_t       src2;
    logic [1:0]      unit;     // mul_completing_next, div_busy
    logic            ma_load;
    logic [XLEN-1:0] ma_addr;
    logic [3:0]      ctl;      // branch, trap, mret, wfi
    logic [4:0]      exp;      // stall, flush, trap check, load-use, mmio pulse
  } row_t;

  logic i_clk;
  logic pipeline_reset;
  logic i_ex_is_load;
  logic i_ex_is_multiply;
  logic i_ex_is_divide;
  logic i_ex_is_csr;
  reg_addr_t i_ex_dest_reg;
  reg_addr_t i_pd_src_reg_1;
  reg_addr_t i_pd_src_reg_2;
  logic i_mul_completing_next;
  logic i_div_busy;
  logic i_ma_is_load;
  logic [XLEN-1:0] i_ma_addr;
  logic i_branch_taken;
  logic i_trap_taken;
  logic i_mret_taken;
  logic i_stall_for_wfi;
  logic o_stall;
  logic o_flush;
  logic o_stall_for_trap_check;
  logic o_load_use_hazard;
  logic o_mmio_read_pulse;
  logic o_vld;
  logic o_pc_vld;

  row_t rows[$];
  logic [31:0] rng_state = 32'd20;
  int test_errors = 0;
  int total_errors = 0;
  int tests_ok = 0;
  int tests_bad = 0;

  hazard_unit_top hazard_unit_top_i (.*);

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // ==================================================
  // Helpers
  // ==================================================

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [XLEN-1:0] random_inside();
    return MMIO_BASE + (xorshift32() % MMIO_SIZE);
  endfunction

  // A hit in the window is folded below the base, which stays outside it
  function automatic logic [XLEN-1:0] random_outside();
    logic [XLEN-1:0] a;
    a = xorshift32();
    if ((a >= MMIO_BASE) && (a < (MMIO_BASE + MMIO_SIZE))) begin
      a = a - MMIO_BASE;
    end
    return a;
  endfunction

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("MISMATCH time %0t %s expected %b actual %b", $time, name, exp, act);
      test_errors++;
    end
  endtask

  task automatic compare_int(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("MISMATCH time %0t %s expected %0d actual %0d", $time, name, exp, act);
      test_errors++;
    end
  endtask

  // Stall, flush and the side outputs are all expected low
  task automatic check_quiet();
    compare_bit("o_stall", 1'b0, o_stall);
    compare_bit("o_flush", 1'b0, o_flush);
    compare_bit("o_stall_for_trap_check", 1'b0, o_stall_for_trap_check);
    compare_bit("o_load_use_hazard", 1'b0, o_load_use_hazard);
    compare_bit("o_mmio_read_pulse", 1'b0, o_mmio_read_pulse);
  endtask

  task automatic finish_test(input string name);
    $display("%s: finished with %0d errors", name, test_errors);
    if (test_errors == 0) begin
      tests_ok++;
    end else begin
      tests_bad++;
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  function automatic string test_name(input int test);
    case (test)
      2: return "load_use";
      3: return "csr_mmio";
      4: return "flush";
      default: return "wfi_trap";
    endcase
  endfunction

  task automatic add_row(input int test, input logic [3:0] ex_cls, input reg_addr_t dest,
                         input reg_addr_t src1, input reg_addr_t src2, input logic [1:0] unit,
                         input logic ma_load, input logic [XLEN-1:0] ma_addr,
                         input logic [3:0] ctl, input logic [4:0] exp);
    row_t r;
    r.test = test;
    r.ex_cls = ex_cls;
    r.dest = dest;
    r.src1 = src1;
    r.src2 = src2;
    r.unit = unit;
    r.ma_load = ma_load;
    r.ma_addr = ma_addr;
    r.ctl = ctl;
    r.exp = exp;
    rows.push_back(r);
  endtask

  task automatic add_idle(input int test);
    add_row(test, 4'b0000, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 32'h0, 4'b0000, 5'b00000);
  endtask

  // ==================================================
  // Stimulus table
  // ==================================================

  task automatic build_table();
    int k;
    logic [XLEN-1:0] a;
    // Matching load in EX, the load then sits in MA for the single bubble
    add_row(2, 4'b1000, 5'd5, 5'd5, 5'd0, 2'b00, 1'b0, 32'h0, 4'b0000, 5'b00000);
    add_row(2, 4'b0000, 5'd0, 5'd0, 5'd0, 2'b00, 1'b1, 32'h0, 4'b0000, 5'b10110);
    add_row(2, 4'b0000, 5'd0, 5'd0, 5'd0, 2'b00, 1'b1, 32'h0, 4'b0000, 5'b00000);
    add_idle(2);
    // x0 destination and a load without a consumer
    add_row(2, 4'b1000, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 32'h0, 4'b0000, 5'b00000);
    add_row(2, 4'b0000, 5'd0, 5'd0, 5'd0, 2'b00, 1'b1, 32'h0, 4'b0000, 5'b00000);
    add_row(2, 4'b1000, 5'd7, 5'd3, 5'd4, 2'b00, 1'b0, 32'h0, 4'b0000, 5'b00000);
    add_row(2, 4'b0000, 5'd0, 5'd0, 5'd0, 2'b00, 1'b1, 32'h0, 4'b0000, 5'b00000);
    add_idle(2);
    // Multiply releases one cycle after the completion prediction
    add_row(2, 4'b0100, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 32'h0, 4'b0000, 5'b10100);
    add_row(2, 4'b0100, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 32'h0, 4'b0000, 5'b10100);
    add_row(2, 4'b0100, 5'd0, 5'd0, 5'd0, 2'b10, 1'b0, 32'h0, 4'b0000, 5'b10100);
    add_row(2, 4'b0100, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 32'h0, 4'b0000, 5'b00000);
    add_idle(2);
    add_row(2, 4'b0010, 5'd0, 5'd0, 5'd0, 2'b01, 1'b0, 32'h0, 4'b0000, 5'b10100);
    add_row(2, 4'b0010, 5'd0, 5'd0, 5'd0, 2'b01, 1'b0, 32'h0, 4'b0000, 5'b10100);
    add_row(2, 4'b0010, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 32'h0, 4'b0000, 5'b00000);
    add_idle(2);

    // CSR stall is invisible to the trap check
    add_row(3, 4'b0001, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 32'h0, 4'b0000, 5'b10000);
    add_row(3, 4'b0001, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 32'h0, 4'b0000, 5'b00000);
    add_idle(3);
    for (k = 0; k < 2; k++) begin
      a = random_inside();
      add_row(3, 4'b0000, 5'd0, 5'd0, 5'd0, 2'b00, 1'b1, a, 4'b0000, 5'b10101);
      add_row(3, 4'b0000, 5'd0, 5'd0, 5'd0, 2'b00, 1'b1, a, 4'b0000, 5'b10100);
      add_row(3, 4'b0000, 5'd0, 5'd0, 5'd0, 2'b00, 1'b1, a, 4'b0000, 5'b00000);
      add_idle(3);
    end
    // The last address is the first byte past the window
    for (k = 0; k < 3; k++) begin
      a = (k == 2) ? (MMIO_BASE + MMIO_SIZE) : random_outside();
      add_row(3, 4'b0000, 5'd0, 5'd0, 5'd0, 2'b00, 1'b1, a, 4'b0000, 5'b00000);
      add_idle(3);
    end

    add_row(4, 4'b0000, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 32'h0, 4'b1000, 5'b01000);
    add_row(4, 4'b0000, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 32'h0, 4'b0000, 5'b01000);
    add_idle(4);
    // Divide stall right after a branch swallows the second flush cycle
    add_row(4, 4'b0000, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 32'h0, 4'b1000, 5'b01000);
    add_row(4, 4'b0010, 5'd0, 5'd0, 5'd0, 2'b01, 1'b0, 32'h0, 4'b0000, 5'b10100);
    add_row(4, 4'b0010, 5'd0, 5'd0, 5'd0, 2'b01, 1'b0, 32'h0, 4'b0000, 5'b10100);
    add_row(4, 4'b0010, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 32'h0, 4'b0000, 5'b00000);
    add_idle(4);
    // A flush in the load cycle drops the pending hazard
    add_row(4, 4'b1000, 5'd5, 5'd5, 5'd0, 2'b00, 1'b0, 32'h0, 4'b1000, 5'b01000);
    add_row(4, 4'b0000, 5'd0, 5'd0, 5'd0, 2'b00, 1'b1, 32'h0, 4'b0000, 5'b01000);
    add_idle(4);

    // WFI ends with a trap, then the same with MRET
    add_row(5, 4'b0000, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 32'h0, 4'b0001, 5'b10100);
    add_row(5, 4'b0000, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 32'h0, 4'b0001, 5'b10100);
    add_row(5, 4'b0000, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 32'h0, 4'b0101, 5'b01100);
    add_row(5, 4'b0000, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 32'h0, 4'b0000, 5'b01000);
    add_idle(5);
    add_row(5, 4'b0000, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 32'h0, 4'b0001, 5'b10100);
    add_row(5, 4'b0000, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 32'h0, 4'b0011, 5'b01100);
    add_row(5, 4'b0000, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 32'h0, 4'b0000, 5'b01000);
    add_idle(5);
  endtask

  // ==================================================
  // Drive and check
  // ==================================================

  task automatic apply_row(input row_t r);
    {i_ex_is_load, i_ex_is_multiply, i_ex_is_divide, i_ex_is_csr} = r.ex_cls;
    i_ex_dest_reg = r.dest;
    i_pd_src_reg_1 = r.src1;
    i_pd_src_reg_2 = r.src2;
    {i_mul_completing_next, i_div_busy} = r.unit;
    i_ma_is_load = r.ma_load;
    i_ma_addr = r.ma_addr;
    {i_branch_taken, i_trap_taken, i_mret_taken, i_stall_for_wfi} = r.ctl;
  endtask

  // The pipe is full by now, so both strobes simply follow the stall
  task automatic check_row(input row_t r);
    compare_bit("o_stall", r.exp[4], o_stall);
    compare_bit("o_flush", r.exp[3], o_flush);
    compare_bit("o_stall_for_trap_check", r.exp[2], o_stall_for_trap_check);
    compare_bit("o_load_use_hazard", r.exp[1], o_load_use_hazard);
    compare_bit("o_mmio_read_pulse", r.exp[0], o_mmio_read_pulse);
    compare_bit("o_vld", !r.exp[4], o_vld);
    compare_bit("o_pc_vld", !r.exp[4], o_pc_vld);
  endtask

  // Counts rising edges after reset until o_vld shows up
  task automatic run_fill();
    int cycles;
    int pc_at;
    int vld_at;
    cycles = 0;
    pc_at = 0;
    vld_at = 0;
    while ((vld_at == 0) && (cycles < FILL_TIMEOUT)) begin
      @(posedge i_clk);
      #5;
      cycles++;
      check_quiet();
      if (o_pc_vld && (pc_at == 0)) pc_at = cycles;
      if (o_vld && (vld_at == 0)) vld_at = cycles;
    end
    if (vld_at == 0) begin
      $display("fill: o_vld was still low after %0d cycles", FILL_TIMEOUT);
      test_errors++;
    end else begin
      compare_int("o_pc_vld rise cycle", PC_VLD_CYCLE, pc_at);
      compare_int("o_vld rise cycle", NUM_STAGES, vld_at);
    end
    finish_test("fill");
  endtask

  task automatic run_table();
    int i;
    int cur;
    cur = rows[0].test;
    for (i = 0; i < rows.size(); i++) begin
      if (rows[i].test != cur) begin
        finish_test(test_name(cur));
        cur = rows[i].test;
      end
      @(posedge i_clk);
      #1;
      apply_row(rows[i]);
      #4;
      check_row(rows[i]);
    end
    finish_test(test_name(cur));
  endtask

  initial begin
    pipeline_reset = 1'b1;
    i_ex_is_load = 1'b0;
    i_ex_is_multiply = 1'b0;
    i_ex_is_divide = 1'b0;
    i_ex_is_csr = 1'b0;
    i_ex_dest_reg = '0;
    i_pd_src_reg_1 = '0;
    i_pd_src_reg_2 = '0;
    i_mul_completing_next = 1'b0;
    i_div_busy = 1'b0;
    i_ma_is_load = 1'b0;
    i_ma_addr = '0;
    i_branch_taken = 1'b0;
    i_trap_taken = 1'b0;
    i_mret_taken = 1'b0;
    i_stall_for_wfi = 1'b0;
    build_table();

    repeat (16) @(posedge i_clk);
    #1;
    // Everything must be low straight out of reset
    check_quiet();
    compare_bit("o_vld", 1'b0, o_vld);
    compare_bit("o_pc_vld", 1'b0, o_pc_vld);
    pipeline_reset = 1'b0;

    run_fill();
    run_table();

    $display("summary: %0d tests ok, %0d tests with errors, %0d mismatches in total",
             tests_ok, tests_bad, total_errors);
    if (tests_bad == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule : hazard_unit_tb

`default_nettype wire

/* source/hazard_unit_top.sv */
/*
  Hazard and flow-control unit of the six-stage pipeline.
  Level inputs are sampled every rising edge, no bus handshake.
*/
`default_nettype none

module hazard_unit_top (
  input  wire logic                        i_clk,
  input  wire logic                        pipeline_reset,
  input  wire logic                        i_ex_is_load,
  input  wire logic                        i_ex_is_multiply,
  input  wire logic                        i_ex_is_divide,
  input  wire logic                        i_ex_is_csr,
  input  wire hazard_pkg::reg_addr_t       i_ex_dest_reg,
  input  wire hazard_pkg::reg_addr_t       i_pd_src_reg_1,
  input  wire hazard_pkg::reg_addr_t       i_pd_src_reg_2,
  input  wire logic                        i_mul_completing_next,
  input  wire logic                        i_div_busy,
  input  wire logic                        i_ma_is_load,
  input  wire logic [hazard_pkg::XLEN-1:0] i_ma_addr,
  input  wire logic                        i_branch_taken,
  input  wire logic                        i_trap_taken,
  input  wire logic                        i_mret_taken,
  input  wire logic                        i_stall_for_wfi,
  output logic                             o_stall,
  output logic                             o_flush,
  output logic                             o_stall_for_trap_check,
  output logic                             o_load_use_hazard,
  output logic                             o_mmio_read_pulse,
  output logic                             o_vld,
  output logic                             o_pc_vld
);

  logic req_mul_div;
  logic req_load_use;
  logic req_csr;
  logic req_mmio;
  logic pipeline_stall;
  logic pipeline_flush;

  // EX attributes bundled for the two request blocks
  ex_stage_if ex_if ();

  assign ex_if.is_load             = i_ex_is_load;
  assign ex_if.is_multiply         = i_ex_is_multiply;
  assign ex_if.is_divide           = i_ex_is_divide;
  assign ex_if.is_csr              = i_ex_is_csr;
  assign ex_if.dest_reg            = i_ex_dest_reg;
  assign ex_if.mul_completing_next = i_mul_completing_next;
  assign ex_if.div_busy            = i_div_busy;

  load_use_detector load_use_detector_i (
    .i_clk             (i_clk),
    .pipeline_reset    (pipeline_reset),
    .ex                (ex_if.hazard_sink),
    .i_pd_src_reg_1    (i_pd_src_reg_1),
    .i_pd_src_reg_2    (i_pd_src_reg_2),
    .i_ma_is_load      (i_ma_is_load),
    .i_stall           (pipeline_stall),
    .i_flush           (pipeline_flush),
    .o_req_mul_div     (req_mul_div),
    .o_req_load_use    (req_load_use),
    .o_load_use_hazard (o_load_use_hazard)
  );

  access_latency_stall access_latency_stall_i (
    .i_clk             (i_clk),
    .pipeline_reset    (pipeline_reset),
    .ex                (ex_if.hazard_sink),
    .i_ma_is_load      (i_ma_is_load),
    .i_ma_addr         (i_ma_addr),
    .i_stall           (pipeline_stall),
    .i_flush           (pipeline_flush),
    .o_req_csr         (req_csr),
    .o_req_mmio        (req_mmio),
    .o_mmio_read_pulse (o_mmio_read_pulse)
  );

  stall_flush_control stall_flush_control_i (
    .i_clk                  (i_clk),
    .pipeline_reset         (pipeline_reset),
    .i_req_mul_div          (req_mul_div),
    .i_req_load_use         (req_load_use),
    .i_req_csr              (req_csr),
    .i_req_mmio             (req_mmio),
    .i_stall_for_wfi        (i_stall_for_wfi),
    .i_branch_taken         (i_branch_taken),
    .i_trap_taken           (i_trap_taken),
    .i_mret_taken           (i_mret_taken),
    .o_stall                (pipeline_stall),
    .o_flush                (pipeline_flush),
    .o_stall_for_trap_check (o_stall_for_trap_check)
  );

  stage_valid_tracker stage_valid_tracker_i (
    .i_clk          (i_clk),
    .pipeline_reset (pipeline_reset),
    .i_stall        (pipeline_stall),
    .o_vld          (o_vld),
    .o_pc_vld       (o_pc_vld)
  );

  assign o_stall = pipeline_stall;
  assign o_flush = pipeline_flush;

endmodule : hazard_unit_top

`default_nettype wire

/* source/stage_valid_tracker.sv */
/*
  Tracks how far the pipeline has filled since reset and gives the valid strobes.
*/
`default_nettype none

module stage_valid_tracker (
  input  wire logic i_clk,
  input  wire logic pipeline_reset,
  input  wire logic i_stall,
  output logic      o_vld,
  output logic      o_pc_vld
);
  import hazard_pkg::*;

  // Bit k is set once stage k has received an instruction
  logic [NUM_STAGES-1:0] fill_sr;

  always_ff @(posedge i_clk) begin
    if (pipeline_reset) begin
      fill_sr <= '0;
    end else if (!i_stall) begin
      fill_sr <= {fill_sr[NUM_STAGES-2:0], 1'b1};
    end
  end

  // Nothing retires or moves in a stalled cycle
  assign o_pc_vld = fill_sr[PC_VALID_STAGE] & ~i_stall;
  assign o_vld    = fill_sr[NUM_STAGES-1] & ~i_stall;

endmodule : stage_valid_tracker

`default_nettype wire

/* source/stall_flush_control.sv */
/*
  Merges the stall requests into the pipeline stall and makes the flush.
  Trap and MRET override every stall and flush for two cycles like a branch.
*/
`default_nettype none

module stall_flush_control (
  input  wire logic i_clk,
  input  wire logic pipeline_reset,
  input  wire logic i_req_mul_div,
  input  wire logic i_req_load_use,
  input  wire logic i_req_csr,
  input  wire logic i_req_mmio,
  input  wire logic i_stall_for_wfi,
  input  wire logic i_branch_taken,
  input  wire logic i_trap_taken,
  input  wire logic i_mret_taken,
  output logic      o_stall,
  output logic      o_flush,
  output logic      o_stall_for_trap_check
);

  logic branch_taken_reg;
  logic trap_taken_reg;
  logic mret_taken_reg;

  // ==================================================
  // Stall merge
  // ==================================================

  // The trap unit sees every source except the CSR read stall,
  // a trap flushes the CSR instruction so waiting on it is pointless
  assign o_stall_for_trap_check = i_req_mul_div | i_req_load_use |
                                  i_req_mmio | i_stall_for_wfi;

  // Trap and MRET break any stall, WFI included
  assign o_stall = (o_stall_for_trap_check | i_req_csr) &
                   ~i_trap_taken & ~i_mret_taken;

  // ==================================================
  // Two-cycle flush
  // ==================================================

  // Second flush cycle comes from these copies, which are cleared
  // in a stall so that no late flush hits the fetch that follows it
  always_ff @(posedge i_clk) begin
    if (pipeline_reset || o_stall) begin
      branch_taken_reg <= 1'b0;
      trap_taken_reg   <= 1'b0;
      mret_taken_reg   <= 1'b0;
    end else begin
      branch_taken_reg <= i_branch_taken;
      trap_taken_reg   <= i_trap_taken;
      mret_taken_reg   <= i_mret_taken;
    end
  end

  // Clears the wrong-path instructions held in PD and ID
  assign o_flush = (i_branch_taken | branch_taken_reg |
                    i_trap_taken | trap_taken_reg |
                    i_mret_taken | mret_taken_reg) & ~o_stall;

endmodule : stall_flush_control

`default_nettype wire

/* source/access_latency_stall.sv */
/*
  Stalls for registered CSR read data and for MMIO loads in MA.
  Also gives the one-cycle pulse that triggers MMIO read side effects.
*/
`default_nettype none

module access_latency_stall (
  input  wire logic                        i_clk,
  input  wire logic                        pipeline_reset,
  ex_stage_if.hazard_sink                  ex,
  input  wire logic                        i_ma_is_load,
  input  wire logic [hazard_pkg::XLEN-1:0] i_ma_addr,
  input  wire logic                        i_stall,
  input  wire logic                        i_flush,
  output logic                             o_req_csr,
  output logic                             o_req_mmio,
  output logic                             o_mmio_read_pulse
);
  import hazard_pkg::*;

  // ==================================================
  // CSR read latency
  // ==================================================

  // Set after the first cycle of a CSR instruction, held while the
  // pipeline is stalled for other reasons, dropped once it advances
  logic csr_wait;

  always_ff @(posedge i_clk) begin
    if (pipeline_reset || i_flush) begin
      csr_wait <= 1'b0;
    end else begin
      csr_wait <= ex.is_csr && (!csr_wait || i_stall);
    end
  end

  assign o_req_csr = ex.is_csr && !csr_wait;

  // ==================================================
  // MMIO load bubble
  // ==================================================

  logic mmio_load_in_ma;
  mmio_state_e mmio_state;
  mmio_state_e mmio_state_next;

  assign mmio_load_in_ma = i_ma_is_load &&
                           (i_ma_addr >= MMIO_BASE) &&
                           (i_ma_addr < (MMIO_BASE + MMIO_SIZE));

  // Each stalled cycle moves one step, DONE waits for the pipe to advance
  always_comb begin
    mmio_state_next = mmio_state;
    unique case (mmio_state)
      MMIO_IDLE: if (mmio_load_in_ma) mmio_state_next = MMIO_WAIT;
      MMIO_WAIT: mmio_state_next = MMIO_DONE;
      MMIO_DONE: mmio_state_next = MMIO_DONE;
      default:   mmio_state_next = MMIO_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (pipeline_reset || i_flush || !i_stall) begin
      mmio_state <= MMIO_IDLE;
    end else begin
      mmio_state <= mmio_state_next;
    end
  end

  assign o_req_mmio = mmio_load_in_ma && (mmio_state != MMIO_DONE);

  // Side effects such as a UART FIFO pop must happen exactly once
  assign o_mmio_read_pulse = mmio_load_in_ma && (mmio_state == MMIO_IDLE);

endmodule : access_latency_stall

`default_nettype wire

/* source/load_use_detector.sv */
/*
  Load-use and multiply/divide stall requests for the instruction in EX.
  The load-use decision is taken one cycle after a registered potential hazard.
*/
`default_nettype none

module load_use_detector (
  input  wire logic                 i_clk,
  input  wire logic                 pipeline_reset,
  ex_stage_if.hazard_sink           ex,
  input  wire hazard_pkg::reg_addr_t i_pd_src_reg_1,
  input  wire hazard_pkg::reg_addr_t i_pd_src_reg_2,
  input  wire logic                 i_ma_is_load,
  input  wire logic                 i_stall,
  input  wire logic                 i_flush,
  output logic                      o_req_mul_div,
  output logic                      o_req_load_use,
  output logic                      o_load_use_hazard
);

  logic dest_matches_src;
  logic potential_hazard;
  logic potential_hazard_reg;
  logic load_seen_reg;
  logic mul_completing_reg;
  logic hazard_detected;

  // Only registered EX fields and the early PD decode feed this compare
  assign dest_matches_src = (ex.dest_reg == i_pd_src_reg_1) ||
                            (ex.dest_reg == i_pd_src_reg_2);

  // Writes to x0 never produce a dependency
  assign potential_hazard = ex.is_load && (ex.dest_reg != '0) && dest_matches_src;

  // A flush discards the consumer, so the hazard goes with it
  always_ff @(posedge i_clk) begin
    if (pipeline_reset || i_flush) begin
      potential_hazard_reg <= 1'b0;
    end else if (!i_stall) begin
      potential_hazard_reg <= potential_hazard;
    end
  end

  // Remembers that the load now in MA has already cost its bubble
  // so the held potential hazard does not stall a second time
  always_ff @(posedge i_clk) begin
    if (pipeline_reset) begin
      load_seen_reg <= 1'b0;
    end else if (!i_stall || o_req_load_use) begin
      load_seen_reg <= i_ma_is_load && !load_seen_reg && o_req_load_use;
    end
  end

  // The multiplier flags completion one cycle ahead, registering it
  // lines the stall release up with the result
  always_ff @(posedge i_clk) begin
    if (pipeline_reset) begin
      mul_completing_reg <= 1'b0;
    end else begin
      mul_completing_reg <= ex.mul_completing_next;
    end
  end

  assign hazard_detected = potential_hazard_reg && !load_seen_reg;

  // Multiply and divide win over load-use, the load data waits in MA anyway
  assign o_req_mul_div = (ex.is_multiply && !mul_completing_reg) ||
                         (ex.is_divide && ex.div_busy);
  assign o_req_load_use = hazard_detected && !o_req_mul_div;

  // Raw detection, visible even when a multiply or divide holds the pipe
  assign o_load_use_hazard = hazard_detected;

endmodule : load_use_detector

`default_nettype wire

/* source/ex_stage_if.sv */
/*
  Attributes of the instruction in EX, as seen by the hazard logic.
*/
`default_nettype none

interface ex_stage_if;
  import hazard_pkg::*;

  // Instruction class decoded for the EX stage
  logic is_load;
  logic is_multiply;
  logic is_divide;
  logic is_csr;
  reg_addr_t dest_reg;
  // Early status from the multiply and divide units
  logic mul_completing_next;
  logic div_busy;

  modport rtl_src (
    output is_load, is_multiply, is_divide, is_csr, dest_reg,
    output mul_completing_next, div_busy
  );

  modport hazard_sink (
    input is_load, is_multiply, is_divide, is_csr, dest_reg,
    input mul_completing_next, div_busy
  );

endinterface : ex_stage_if

`default_nettype wire

/* source/hazard_pkg.sv */
/*
  Shared pipeline geometry, MMIO window and types for the hazard unit.
  Modules import it in their bodies and use scoped names in their headers.
*/
`default_nettype none

package hazard_pkg;

  // Six stages, IF PD ID EX MA WB, indexed from zero
  localparam int unsigned NUM_STAGES = 6;
  // The PC becomes valid once the ID stage holds an instruction
  localparam int unsigned PC_VALID_STAGE = 2;

  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned XLEN = 32;

  // Memory-mapped peripherals whose reads have side effects
  localparam logic [XLEN-1:0] MMIO_BASE = 32'h4000_0000;
  localparam logic [XLEN-1:0] MMIO_SIZE = 32'h28;
  localparam int unsigned MMIO_STALL_CYCLES = 2;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // The encoding counts the stalled cycles spent so far on one MMIO load
  typedef enum logic [1:0] {
    MMIO_IDLE = 2'd0,
    MMIO_WAIT = 2'd1,
    MMIO_DONE = 2'(MMIO_STALL_CYCLES)
  } mmio_state_e;

endpackage : hazard_pkg

`default_nettype wire
